// ==== filelist.f ====
+incdir+verification
design/rtu_pkg.sv
design/rtu_cmplt_ctrl.sv
design/rtu_cmplt_dp.sv
design/rtu_retire.sv
design/rtu_apb_regs.sv
design/rtu_top.sv
verification/rtu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run rtu_tb, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module rtu_tb -f filelist.f -o rtu_sim
	./obj_dir/rtu_sim | tee sim.log
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/rtu_tb_ref.svh ====
  //========================================
  // Reference model state
  //========================================
  // Model copy of the EX2 stage
  logic             m_ex2_vld;
  rtu_ex1_pld_t     m_ex2;
  // Model copy of the register block
  logic [XLEN-1:0]  m_tvec;
  logic [XLEN-1:0]  m_instret;
  logic [XLEN-1:0]  m_exptcnt;
  logic [XLEN-1:0]  m_flushcnt;
  logic [XLEN-1:0]  m_lastpc;

  // Expected retire outputs for one cycle
  typedef struct packed {
    logic            wb_vld;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            redir_vld;
    logic [XLEN-1:0] redir_pc;
    logic            clear;
  } ref_out_t;

  function automatic void model_reset();
    m_ex2_vld  = 1'b0;
    m_ex2      = '0;
    m_tvec     = {TVEC_RST[XLEN-1:2], 2'b00};
    m_instret  = '0;
    m_exptcnt  = '0;
    m_flushcnt = '0;
    m_lastpc   = '0;
  endfunction

  // Writeback, redirect and commit clear for the EX2 instruction
  function automatic ref_out_t ref_retire(logic vld, rtu_ex1_pld_t p, logic [XLEN-1:0] base);
    ref_out_t o;
    o = '0;
    if (vld && p.expt)
    begin
      // Vectored trap, no writeback
      o.redir_vld = 1'b1;
      o.redir_pc  = base + {26'd0, p.expt_code, 2'b00};
    end
    else if (vld)
    begin
      o.redir_vld = p.redirect;
      o.redir_pc  = p.result;
      o.wb_rd     = p.rd;
      // Link address on a taken branch
      o.wb_data   = p.redirect ? p.pc + 32'd4 : p.result;
      o.wb_vld    = p.wb_en && (p.rd != 5'd0);
    end
    o.clear = o.redir_vld;
    return o;
  endfunction

  // Expected APB read data and slave error
  function automatic logic [XLEN-1:0] ref_read(logic [7:0] addr, logic wr, output logic err);
    logic [XLEN-1:0] data;
    data = '0;
    err  = wr;
    case (addr)
      RTU_REG_TVEC:
      begin
        data = m_tvec;
        err  = 1'b0;
      end
      RTU_REG_INSTRET:  data = m_instret;
      RTU_REG_EXPTCNT:  data = m_exptcnt;
      RTU_REG_FLUSHCNT: data = m_flushcnt;
      RTU_REG_LASTPC:   data = m_lastpc;
      default:          err  = 1'b1;
    endcase
    return data;
  endfunction

  // Counter updates and EX2 load at the coming clock edge
  function automatic void model_step(logic clear, rtu_unit_vec_t unit, rtu_ex1_pld_t p,
                                     logic tvec_wr, logic [XLEN-1:0] wdata);
    logic ok;
    logic ex;
    ok = m_ex2_vld && !m_ex2.expt;
    ex = m_ex2_vld && m_ex2.expt;
    if (ok)
      m_instret = m_instret + 32'd1;
    if (ex)
      m_exptcnt = m_exptcnt + 32'd1;
    if (ok || ex)
      m_lastpc = m_ex2.pc;
    // Completion killed by the clear
    if ((unit != '0) && clear)
      m_flushcnt = m_flushcnt + 32'd1;
    if (tvec_wr)
      m_tvec = {wdata[XLEN-1:2], 2'b00};
    m_ex2_vld = (unit != '0) && !clear;
    if (m_ex2_vld)
    begin
      m_ex2          = p;
      // Redirect only from bju, no traps from mul or div
      m_ex2.redirect = p.redirect & unit.bju;
      m_ex2.expt     = p.expt & ~(unit.mul | unit.div);
    end
  endfunction

// ==== verification/rtu_tb.sv ====
module rtu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rtu_pkg::*;

  localparam logic [XLEN-1:0] TVEC_RST = 32'h0000_0100;
  // Cycles allowed for any wait
  localparam int TMO = 20;
  // Bit positions in rtu_unit_vec_t
  localparam int U_ALU = 4;
  localparam int U_MUL = 3;
  localparam int U_BJU = 1;
  localparam int U_LSU = 0;

  logic                  cmplt_clk;
  logic                  cpurst_b;
  rtu_unit_vec_t         unit_cmplt;
  rtu_ex1_pld_t          ex1_pld;
  logic                  wb_vld;
  logic [4:0]            wb_rd;
  logic [XLEN-1:0]       wb_data;
  logic                  redirect_vld;
  logic [XLEN-1:0]       redirect_pc;
  logic                  commit;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [RTU_ADDR_W-1:0] paddr;
  logic [XLEN-1:0]       pwdata;
  logic [XLEN-1:0]       prdata;
  logic                  pready;
  logic                  pslverr;
  // Error bookkeeping
  int test_errs;
  int err_total;
  int n_tests;
  int n_failed;

  `include "rtu_tb_ref.svh"

  ref_out_t        exp_o;
  logic [XLEN-1:0] exp_rd;
  logic            exp_err;

  rtu_top #(
    .TVEC_RESET (TVEC_RST),
    .CNT_W      (32)
  ) rtu_top_inst (.*);

  initial
  begin
    cmplt_clk = 1'b0;
    forever #20 cmplt_clk = ~cmplt_clk;
  end

  task automatic check_val(input string name, input logic [XLEN-1:0] act,
                           input logic [XLEN-1:0] exp);
    if (act !== exp)
    begin
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, act, exp);
      test_errs = test_errs + 1;
      err_total = err_total + 1;
    end
  endtask

  //========================================
  // Mid-cycle scoreboard
  //========================================
  always @(negedge cmplt_clk)
  begin
    if (!cpurst_b)
      model_reset();
    else
    begin
      exp_o = ref_retire(m_ex2_vld, m_ex2, m_tvec);
      check_val("wb_vld", wb_vld, exp_o.wb_vld);
      if (exp_o.wb_vld)
      begin
        check_val("wb_rd", wb_rd, exp_o.wb_rd);
        check_val("wb_data", wb_data, exp_o.wb_data);
      end
      check_val("redirect_vld", redirect_vld, exp_o.redir_vld);
      if (exp_o.redir_vld)
        check_val("redirect_pc", redirect_pc, exp_o.redir_pc);
      check_val("commit", commit, !exp_o.clear);
      // APB access phase
      exp_err = 1'b0;
      if (psel && penable)
      begin
        check_val("pready", pready, 1'b1);
        exp_rd = ref_read(paddr, pwrite, exp_err);
        if (!pwrite && !exp_err)
          check_val("prdata", prdata, exp_rd);
      end
      check_val("pslverr", pslverr, exp_err);
      model_step(exp_o.clear, unit_cmplt, ex1_pld,
                 psel && penable && pwrite && (paddr == RTU_REG_TVEC), pwdata);
    end
  end

  //========================================
  // Stimulus helpers
  //========================================
  function automatic rtu_ex1_pld_t rand_pld(logic redir, logic expt);
    rtu_ex1_pld_t p;
    p.pc        = $urandom() & 32'hffff_fffc;
    p.result    = $urandom();
    p.rd        = 5'($urandom_range(31, 0));
    p.wb_en     = 1'($urandom_range(1, 0));
    p.redirect  = redir;
    p.expt      = expt;
    p.expt_code = 4'($urandom_range(15, 0));
    return p;
  endfunction

  // One completion held for one cycle
  task automatic issue(input int unit, input rtu_ex1_pld_t p);
    unit_cmplt = rtu_unit_vec_t'(5'b1 << unit);
    ex1_pld    = p;
    @(posedge cmplt_clk);
    #2;
    unit_cmplt = '0;
  endtask

  task automatic idle(input int n);
    unit_cmplt = '0;
    repeat (n)
    begin
      @(posedge cmplt_clk);
      #2;
    end
  endtask

  // Retire outputs quiet before register reads
  task automatic wait_retire_idle();
    int cnt;
    cnt = 0;
    @(negedge cmplt_clk);
    while ((wb_vld || redirect_vld) && (cnt < TMO))
    begin
      cnt = cnt + 1;
      @(negedge cmplt_clk);
    end
    if (wb_vld || redirect_vld)
    begin
      $display("timeout: retire outputs stayed active for %0d cycles", TMO);
      $display("STATUS: FAIL");
      $finish;
    end
    else
    begin
      @(posedge cmplt_clk);
      #2;
    end
  endtask

  // APB transfer checked by the scoreboard in the access phase
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [XLEN-1:0] data);
    int cnt;
    cnt     = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge cmplt_clk);
    #2;
    penable = 1'b1;
    @(negedge cmplt_clk);
    while (!pready && (cnt < TMO))
    begin
      cnt = cnt + 1;
      @(negedge cmplt_clk);
    end
    if (!pready)
    begin
      $display("timeout: pready did not rise within %0d cycles", TMO);
      $display("STATUS: FAIL");
      $finish;
    end
    else
    begin
      @(posedge cmplt_clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    n_tests = n_tests + 1;
    if (test_errs != 0)
      n_failed = n_failed + 1;
    test_errs = 0;
  endtask

  //========================================
  // Test sequence
  //========================================
  initial
  begin
    rtu_ex1_pld_t p;
    void'($urandom(32'h1c0cfe7e));
    test_errs  = 0;
    err_total  = 0;
    n_tests    = 0;
    n_failed   = 0;
    cpurst_b   = 1'b0;
    unit_cmplt = '0;
    ex1_pld    = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    repeat (4) @(posedge cmplt_clk);
    #2;
    cpurst_b = 1'b1;

    // Reset values
    idle(1);
    apb_xfer(1'b0, RTU_REG_TVEC, '0);
    apb_xfer(1'b0, RTU_REG_INSTRET, '0);
    apb_xfer(1'b0, RTU_REG_EXPTCNT, '0);
    apb_xfer(1'b0, RTU_REG_FLUSHCNT, '0);
    apb_xfer(1'b0, RTU_REG_LASTPC, '0);
    end_test("reset");

    // Plain results including x0 and wb_en clear
    repeat (12) issue($urandom_range(4, 0), rand_pld(1'b0, 1'b0));
    p       = rand_pld(1'b0, 1'b0);
    p.rd    = 5'd0;
    p.wb_en = 1'b1;
    issue(U_LSU, p);
    p.rd    = 5'd7;
    p.wb_en = 1'b0;
    issue(U_ALU, p);
    idle(2);
    end_test("plain");

    // Trap with a younger completion behind it
    issue(U_ALU, rand_pld(1'b0, 1'b1));
    issue(U_LSU, rand_pld(1'b0, 1'b0));
    idle(2);
    apb_xfer(1'b0, RTU_REG_FLUSHCNT, '0);
    apb_xfer(1'b0, RTU_REG_EXPTCNT, '0);
    end_test("exception");

    // Taken branch with link and then masked redirects
    p       = rand_pld(1'b1, 1'b0);
    p.rd    = 5'd1;
    p.wb_en = 1'b1;
    issue(U_BJU, p);
    issue(U_ALU, rand_pld(1'b0, 1'b0));
    idle(1);
    issue(U_ALU, rand_pld(1'b1, 1'b0));
    issue(U_MUL, rand_pld(1'b1, 1'b1));
    idle(2);
    end_test("branch");

    // New trap base followed by a random stream and error responses
    apb_xfer(1'b1, RTU_REG_TVEC, $urandom());
    issue(U_LSU, rand_pld(1'b0, 1'b1));
    idle(1);
    repeat (40)
    begin
      issue($urandom_range(4, 0), rand_pld($urandom_range(3, 0) == 0, $urandom_range(7, 0) == 0));
      if ($urandom_range(3, 0) == 0)
        idle(1);
    end
    wait_retire_idle();
    apb_xfer(1'b0, RTU_REG_INSTRET, '0);
    apb_xfer(1'b0, RTU_REG_EXPTCNT, '0);
    apb_xfer(1'b0, RTU_REG_FLUSHCNT, '0);
    apb_xfer(1'b0, RTU_REG_LASTPC, '0);
    apb_xfer(1'b0, 8'h14, '0);
    apb_xfer(1'b1, RTU_REG_INSTRET, $urandom());
    apb_xfer(1'b0, RTU_REG_INSTRET, '0);
    end_test("apb");

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_total);
    if (err_total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== design/rtu_top.sv ====
module rtu_top #(
  parameter logic [rtu_pkg::XLEN-1:0] TVEC_RESET = 32'h0000_0100,
  parameter int                       CNT_W      = 32
) (
  input  logic                           cmplt_clk,
  input  logic                           cpurst_b,
  // EX1 completion
  input  rtu_pkg::rtu_unit_vec_t         unit_cmplt,
  input  rtu_pkg::rtu_ex1_pld_t          ex1_pld,
  // Register file write port
  output logic                           wb_vld,
  output logic [4:0]                     wb_rd,
  output logic [rtu_pkg::XLEN-1:0]       wb_data,
  // Fetch redirect
  output logic                           redirect_vld,
  output logic [rtu_pkg::XLEN-1:0]       redirect_pc,
  // To decode
  output logic                           commit,
  // APB slave
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [rtu_pkg::RTU_ADDR_W-1:0] paddr,
  input  logic [rtu_pkg::XLEN-1:0]       pwdata,
  output logic [rtu_pkg::XLEN-1:0]       prdata,
  output logic                           pready,
  output logic                           pslverr
);

  import rtu_pkg::*;

  // Stage control
  logic            ex1_load;
  logic            ex2_vld;
  logic            flush_ex1;
  logic            commit_clear;
  // EX2 record and retire event
  rtu_ex2_rec_t    ex2_rec;
  rtu_retire_evt_t retire_evt;
  // Trap base from the register block
  logic [XLEN-1:0] tvec;

  //========================================
  // Completion
  //========================================
  rtu_cmplt_ctrl x_cmplt_ctrl (
    .cmplt_clk    (cmplt_clk),
    .cpurst_b     (cpurst_b),
    .unit_cmplt   (unit_cmplt),
    .commit_clear (commit_clear),
    .ex1_load     (ex1_load),
    .ex2_vld      (ex2_vld),
    .flush_ex1    (flush_ex1),
    .commit       (commit)
  );

  rtu_cmplt_dp x_cmplt_dp (
    .cmplt_clk  (cmplt_clk),
    .cpurst_b   (cpurst_b),
    .ex1_load   (ex1_load),
    .unit_cmplt (unit_cmplt),
    .ex1_pld    (ex1_pld),
    .ex2_rec    (ex2_rec)
  );

  //========================================
  // Retire and registers
  //========================================
  rtu_retire x_retire (
    .ex2_vld      (ex2_vld),
    .ex2_rec      (ex2_rec),
    .flush_ex1    (flush_ex1),
    .tvec         (tvec),
    .commit_clear (commit_clear),
    .wb_vld       (wb_vld),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .redirect_vld (redirect_vld),
    .redirect_pc  (redirect_pc),
    .retire_evt   (retire_evt)
  );

  rtu_apb_regs #(
    .TVEC_RESET (TVEC_RESET),
    .CNT_W      (CNT_W)
  ) x_apb_regs (
    .cmplt_clk  (cmplt_clk),
    .cpurst_b   (cpurst_b),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .retire_evt (retire_evt),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .tvec       (tvec)
  );

endmodule

// ==== design/rtu_apb_regs.sv ====
module rtu_apb_regs #(
  parameter logic [rtu_pkg::XLEN-1:0] TVEC_RESET = 32'h0000_0100,
  parameter int                       CNT_W      = 32
) (
  input  logic                           cmplt_clk,
  input  logic                           cpurst_b,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [rtu_pkg::RTU_ADDR_W-1:0] paddr,
  input  logic [rtu_pkg::XLEN-1:0]       pwdata,
  input  rtu_pkg::rtu_retire_evt_t       retire_evt,
  output logic [rtu_pkg::XLEN-1:0]       prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic [rtu_pkg::XLEN-1:0]       tvec
);

  import rtu_pkg::*;

  // APB phase decode
  logic             apb_acc;
  logic             apb_wr;
  logic             addr_hit;
  logic             addr_ro;
  // Register state
  logic [XLEN-1:0]  tvec_q;
  logic [XLEN-1:0]  lastpc_q;
  logic [CNT_W-1:0] instret_q;
  logic [CNT_W-1:0] exptcnt_q;
  logic [CNT_W-1:0] flushcnt_q;

  //========================================
  // APB access
  //========================================
  assign apb_acc = psel & penable;
  assign apb_wr  = apb_acc & pwrite;
  // No wait states
  assign pready  = 1'b1;

  // Offset decode and read mux
  always_comb
  begin
    addr_hit = 1'b1;
    addr_ro  = 1'b1;
    prdata   = '0;
    case (paddr)
      RTU_REG_TVEC:
      begin
        addr_ro = 1'b0;
        prdata  = tvec_q;
      end
      RTU_REG_INSTRET:  prdata = XLEN'(instret_q);
      RTU_REG_EXPTCNT:  prdata = XLEN'(exptcnt_q);
      RTU_REG_FLUSHCNT: prdata = XLEN'(flushcnt_q);
      RTU_REG_LASTPC:   prdata = lastpc_q;
      default:
      begin
        addr_hit = 1'b0;
        addr_ro  = 1'b0;
      end
    endcase
  end

  // Unmapped offset, or write to a counter
  assign pslverr = apb_acc & (~addr_hit | (pwrite & addr_ro));

  //========================================
  // Trap vector and retire counters
  //========================================
  always_ff @(posedge cmplt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      tvec_q     <= {TVEC_RESET[XLEN-1:2], 2'b00};
      instret_q  <= '0;
      exptcnt_q  <= '0;
      flushcnt_q <= '0;
      lastpc_q   <= '0;
    end
    else
    begin
      // Word aligned base
      if (apb_wr && (paddr == RTU_REG_TVEC))
        tvec_q <= {pwdata[XLEN-1:2], 2'b00};
      // Counters wrap at CNT_W
      if (retire_evt.ok)
        instret_q <= instret_q + 1'b1;
      if (retire_evt.expt)
        exptcnt_q <= exptcnt_q + 1'b1;
      if (retire_evt.flush)
        flushcnt_q <= flushcnt_q + 1'b1;
      // Trapping PC is kept too
      if (retire_evt.ok || retire_evt.expt)
        lastpc_q <= retire_evt.pc;
    end
  end

  assign tvec = tvec_q;

endmodule

// ==== design/rtu_retire.sv ====
module rtu_retire (
  input  logic                     ex2_vld,
  input  rtu_pkg::rtu_ex2_rec_t    ex2_rec,
  input  logic                     flush_ex1,
  input  logic [rtu_pkg::XLEN-1:0] tvec,
  output logic                     commit_clear,
  output logic                     wb_vld,
  output logic [4:0]               wb_rd,
  output logic [rtu_pkg::XLEN-1:0] wb_data,
  output logic                     redirect_vld,
  output logic [rtu_pkg::XLEN-1:0] redirect_pc,
  output rtu_pkg::rtu_retire_evt_t retire_evt
);

  import rtu_pkg::*;

  // Retire classification
  logic            ex2_expt;
  logic            ex2_br;
  logic            ex2_ok;
  logic            rd_nz;
  // Computed addresses
  logic [XLEN-1:0] expt_ofs;
  logic [XLEN-1:0] expt_pc;
  logic [XLEN-1:0] link_pc;

  //========================================
  // Classify the EX2 instruction
  //========================================
  // Exception has priority over a redirect
  assign ex2_expt = ex2_vld & ex2_rec.pld.expt;
  assign ex2_br   = ex2_vld & ex2_rec.pld.redirect & ~ex2_rec.pld.expt;
  // Normal retire, branches included
  assign ex2_ok   = ex2_vld & ~ex2_rec.pld.expt;

  // Either event kills EX1 this cycle
  assign commit_clear = ex2_expt | ex2_br;

  //========================================
  // Redirect
  //========================================
  // Vectored trap entry, four bytes per code
  assign expt_ofs = {{(XLEN-6){1'b0}}, ex2_rec.pld.expt_code, 2'b00};
  assign expt_pc  = tvec + expt_ofs;

  assign redirect_vld = ex2_expt | ex2_br;
  // Branch target travels on the result field
  assign redirect_pc  = ex2_expt ? expt_pc : ex2_rec.pld.result;

  //========================================
  // Writeback
  //========================================
  // Return address for jump-and-link
  assign link_pc = ex2_rec.pld.pc + XLEN'(4);

  // x0 is never written
  assign rd_nz = |ex2_rec.pld.rd;

  // Trapping instruction leaves rd untouched
  assign wb_vld  = ex2_ok & ex2_rec.pld.wb_en & rd_nz;
  assign wb_rd   = ex2_rec.pld.rd;
  assign wb_data = ex2_br ? link_pc : ex2_rec.pld.result;

  //========================================
  // Retire event for the counters
  //========================================
  // flush marks the EX1 instruction killed
  // in this same cycle
  assign retire_evt = '{ok:    ex2_ok,
                        expt:  ex2_expt,
                        flush: flush_ex1,
                        pc:    ex2_rec.pld.pc};

endmodule

// ==== design/rtu_cmplt_dp.sv ====
module rtu_cmplt_dp (
  input  logic                   cmplt_clk,
  input  logic                   cpurst_b,
  input  logic                   ex1_load,
  input  rtu_pkg::rtu_unit_vec_t unit_cmplt,
  input  rtu_pkg::rtu_ex1_pld_t  ex1_pld,
  output rtu_pkg::rtu_ex2_rec_t  ex2_rec
);

  import rtu_pkg::*;

  // Masked flags from EX1
  logic            ex1_redirect;
  logic            ex1_expt;
  // Control part of the record
  rtu_unit_vec_t   unit_q;
  logic            wb_en_q;
  logic            redirect_q;
  logic            expt_q;
  // Payload part of the record
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] result_q;
  logic [4:0]      rd_q;
  logic [3:0]      expt_code_q;

  //========================================
  // Flag masking by unit
  //========================================
  // Only the branch unit may redirect
  assign ex1_redirect = ex1_pld.redirect & unit_cmplt.bju;
  // mul and div never trap
  assign ex1_expt     = ex1_pld.expt & ~(unit_cmplt.mul | unit_cmplt.div);

  //========================================
  // EX2 record
  //========================================
  always_ff @(posedge cmplt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      unit_q     <= '0;
      wb_en_q    <= 1'b0;
      redirect_q <= 1'b0;
      expt_q     <= 1'b0;
    end
    else if (ex1_load)
    begin
      unit_q     <= unit_cmplt;
      wb_en_q    <= ex1_pld.wb_en;
      redirect_q <= ex1_redirect;
      expt_q     <= ex1_expt;
    end
  end

  // Data fields, held while no load
  always_ff @(posedge cmplt_clk)
  begin
    if (ex1_load)
    begin
      pc_q        <= ex1_pld.pc;
      result_q    <= ex1_pld.result;
      rd_q        <= ex1_pld.rd;
      expt_code_q <= ex1_pld.expt_code;
    end
  end

  assign ex2_rec = '{pld: '{pc:        pc_q,
                            result:    result_q,
                            rd:        rd_q,
                            wb_en:     wb_en_q,
                            redirect:  redirect_q,
                            expt:      expt_q,
                            expt_code: expt_code_q},
                     unit: unit_q};

endmodule

// ==== design/rtu_cmplt_ctrl.sv ====
module rtu_cmplt_ctrl (
  input  logic                   cmplt_clk,
  input  logic                   cpurst_b,
  input  rtu_pkg::rtu_unit_vec_t unit_cmplt,
  input  logic                   commit_clear,
  output logic                   ex1_load,
  output logic                   ex2_vld,
  output logic                   flush_ex1,
  output logic                   commit
);

  // Merged EX1 completion
  logic ex1_cmplt;
  // Per-unit completions
  logic ex1_alu_cmplt;
  logic ex1_mul_cmplt;
  logic ex1_div_cmplt;
  logic ex1_bju_cmplt;
  logic ex1_lsu_cmplt;
  // EX2 valid flop
  logic ex2_cmplt_q;

  //========================================
  // EX1 completion merge
  //========================================
  // Units sharing the EX1 bus
  assign ex1_alu_cmplt = unit_cmplt.alu;
  assign ex1_mul_cmplt = unit_cmplt.mul;
  assign ex1_div_cmplt = unit_cmplt.div;
  assign ex1_bju_cmplt = unit_cmplt.bju;
  assign ex1_lsu_cmplt = unit_cmplt.lsu;

  // Any unit done this cycle
  assign ex1_cmplt = ex1_alu_cmplt
                   | ex1_mul_cmplt
                   | ex1_div_cmplt
                   | ex1_bju_cmplt
                   | ex1_lsu_cmplt;

  //========================================
  // Commit clear qualification
  //========================================
  // Clear comes from the EX2 instruction
  // Exception or taken redirect kills the
  // younger instruction sitting in EX1
  assign ex1_load  = ex1_cmplt & ~commit_clear;

  // Killed completion, counted by retire
  assign flush_ex1 = ex1_cmplt & commit_clear;

  // Decode may commit unless EX2 clears
  assign commit    = ~commit_clear;

  //========================================
  // EX2 valid
  //========================================
  always_ff @(posedge cmplt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_cmplt_q <= 1'b0;
    else
      ex2_cmplt_q <= ex1_load;
  end

  // Retire stage sees one instruction per cycle at most
  assign ex2_vld = ex2_cmplt_q;

endmodule

// ==== design/rtu_pkg.sv ====
package rtu_pkg;

  //========================================
  // Widths
  //========================================
  // Data and address width of the core
  localparam int XLEN = 32;
  // APB offset width, covers the register window
  localparam int RTU_ADDR_W = 8;

  //========================================
  // Completion flags and EX1 bus
  //========================================
  // One flag per execution unit, one-hot per cycle
  typedef struct packed {
    logic alu;
    logic mul;
    logic div;
    logic bju;
    logic lsu;
  } rtu_unit_vec_t;

  // Shared EX1 result bus
  typedef struct packed {
    logic [XLEN-1:0] pc;
    // Branch target on a bju redirect
    logic [XLEN-1:0] result;
    logic [4:0]      rd;
    logic            wb_en;
    logic            redirect;
    logic            expt;
    logic [3:0]      expt_code;
  } rtu_ex1_pld_t;

  // EX2 record, bus payload plus completing unit
  typedef struct packed {
    rtu_ex1_pld_t  pld;
    rtu_unit_vec_t unit;
  } rtu_ex2_rec_t;

  // Retire event, one cycle wide
  typedef struct packed {
    logic            ok;
    logic            expt;
    logic            flush;
    logic [XLEN-1:0] pc;
  } rtu_retire_evt_t;

  //========================================
  // Register map
  //========================================
  localparam logic [RTU_ADDR_W-1:0] RTU_REG_TVEC     = 8'h00;
  localparam logic [RTU_ADDR_W-1:0] RTU_REG_INSTRET  = 8'h04;
  localparam logic [RTU_ADDR_W-1:0] RTU_REG_EXPTCNT  = 8'h08;
  localparam logic [RTU_ADDR_W-1:0] RTU_REG_FLUSHCNT = 8'h0C;
  localparam logic [RTU_ADDR_W-1:0] RTU_REG_LASTPC   = 8'h10;

endpackage
